/* common/tsn_cfg_pkg.sv */
// Shared widths, block identifiers and gate patterns of the TSN configuration core
package tsn_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Host access
    ////////////////////////////////////////////////////////////

    typedef logic [18:0] cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [1:0]  block_id_t;

    // Target blocks, ids 2 and 3 are unused
    localparam block_id_t BLK_GLOBAL = 2'd0;
    localparam block_id_t BLK_GATE   = 2'd1;

    ////////////////////////////////////////////////////////////
    // Configuration fields
    ////////////////////////////////////////////////////////////

    typedef logic [2:0]  hw_stage_t;
    typedef logic [8:0]  threshold_t;
    // Slot length in clocks, also the period in slots
    typedef logic [10:0] slot_len_t;

    localparam hw_stage_t STAGE_RUNNING = 3'd3;

    ////////////////////////////////////////////////////////////
    // Gate control
    ////////////////////////////////////////////////////////////

    // One open bit per egress queue
    typedef logic [7:0] gate_state_t;

    localparam gate_state_t GATE_ALL_OPEN = 8'b1111_1111;

    // Qch alternates between queue 6 and queue 7 closed
    localparam gate_state_t QCH_GATE_EVEN = 8'b1011_1111;
    localparam gate_state_t QCH_GATE_ODD  = 8'b0111_1111;

endpackage

/* gate_control/gate_control_list.sv */
// Gate control list memory with a host access port and a scheduler read port
`timescale 1ns/100ps

module gate_control_list
    import tsn_cfg_pkg::*;
#(
    parameter int GCL_DEPTH = 16,
    localparam int SLOT_W = $clog2(GCL_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wr,
    input  logic              i_rd,
    input  cfg_addr_t         i_addr,
    input  logic              i_addr_fixed,
    input  cfg_data_t         i_wdata,
    output logic              o_rpl_valid,
    output cfg_addr_t         o_rpl_addr,
    output logic              o_rpl_addr_fixed,
    output cfg_data_t         o_rpl_data,
    input  logic [SLOT_W-1:0] i_slot_index,
    output gate_state_t       o_slot_gate
);

    gate_state_t       gcl_mem [GCL_DEPTH];
    logic              host_hit;
    logic [SLOT_W-1:0] host_idx;

    // Entries live at address-fixed 0 only
    assign host_hit = !i_addr_fixed && (i_addr < cfg_addr_t'(GCL_DEPTH));
    assign host_idx = i_addr[SLOT_W-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < GCL_DEPTH; i++) begin
                gcl_mem[i] <= '0;
            end
            o_slot_gate <= '0;
        end else begin
            if (i_wr && host_hit) begin
                gcl_mem[host_idx] <= i_wdata[7:0];
            end
            // Scheduler port
            if (int'(i_slot_index) < GCL_DEPTH) begin
                o_slot_gate <= gcl_mem[i_slot_index];
            end else begin
                o_slot_gate <= '0;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rpl_valid      <= 1'b0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end else if (i_rd && !i_wr && host_hit) begin
            o_rpl_valid      <= 1'b1;
            o_rpl_addr       <= i_addr;
            o_rpl_addr_fixed <= i_addr_fixed;
            o_rpl_data       <= cfg_data_t'(gcl_mem[host_idx]);
        end else begin
            o_rpl_valid      <= 1'b0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end
    end

endmodule

/* gate_control/time_slot_scheduler.sv */
// Time-slot scheduler that steps through slots and selects the egress gate state
`timescale 1ns/100ps

module time_slot_scheduler
    import tsn_cfg_pkg::*;
#(
    parameter int GCL_DEPTH = 16,
    localparam int SLOT_W = $clog2(GCL_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  hw_stage_t         i_hardware_stage,
    input  logic              i_qbv_or_qch,
    input  slot_len_t         i_time_slot_length,
    input  slot_len_t         i_schedule_period,
    input  gate_state_t       i_slot_gate,
    output logic [SLOT_W-1:0] o_slot_index,
    output gate_state_t       o_gate_state
);

    slot_len_t   cycle_cnt;
    logic        slot_end;
    logic        period_end;
    logic        use_gcl;
    gate_state_t fixed_gate;

    ////////////////////////////////////////////////////////////
    // Slot timing
    ////////////////////////////////////////////////////////////

    // Also ends the slot when the length shrinks below the count
    assign slot_end   = (cycle_cnt + 11'd1 >= i_time_slot_length);
    assign period_end = (slot_len_t'(o_slot_index) + 11'd1 >= i_schedule_period);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cycle_cnt    <= '0;
            o_slot_index <= '0;
        end else if (slot_end) begin
            cycle_cnt    <= '0;
            o_slot_index <= period_end ? '0 : o_slot_index + 1'b1;
        end else begin
            cycle_cnt <= cycle_cnt + 11'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Gate state selection
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            use_gcl    <= 1'b0;
            fixed_gate <= GATE_ALL_OPEN;
        end else begin
            use_gcl <= (i_hardware_stage == STAGE_RUNNING) && i_qbv_or_qch;
            if (i_hardware_stage != STAGE_RUNNING) begin
                fixed_gate <= GATE_ALL_OPEN;
            end else if (o_slot_index[0]) begin
                fixed_gate <= QCH_GATE_ODD;
            end else begin
                fixed_gate <= QCH_GATE_EVEN;
            end
        end
    end

    // List entry already lags the index by one cycle, same as the select
    assign o_gate_state = use_gcl ? i_slot_gate : fixed_gate;

endmodule

/* hdl/cfg_access_router.sv */
// Access router that forwards host commands to the register blocks and returns replies
`timescale 1ns/100ps

module cfg_access_router
    import tsn_cfg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    // Host command
    input  logic      i_cmd_wr,
    input  logic      i_cmd_rd,
    input  block_id_t i_cmd_block,
    input  cfg_addr_t i_cmd_addr,
    input  logic      i_cmd_addr_fixed,
    input  cfg_data_t i_cmd_wdata,
    // Block commands
    output logic      o_glb_wr,
    output logic      o_glb_rd,
    output logic      o_gcl_wr,
    output logic      o_gcl_rd,
    output cfg_addr_t o_blk_addr,
    output logic      o_blk_addr_fixed,
    output cfg_data_t o_blk_wdata,
    // Block replies
    input  logic      i_glb_rpl_valid,
    input  cfg_addr_t i_glb_rpl_addr,
    input  logic      i_glb_rpl_addr_fixed,
    input  cfg_data_t i_glb_rpl_data,
    input  logic      i_gcl_rpl_valid,
    input  cfg_addr_t i_gcl_rpl_addr,
    input  logic      i_gcl_rpl_addr_fixed,
    input  cfg_data_t i_gcl_rpl_data,
    // Host reply
    output logic      o_rpl_valid,
    output block_id_t o_rpl_block,
    output cfg_addr_t o_rpl_addr,
    output logic      o_rpl_addr_fixed,
    output cfg_data_t o_rpl_data
);

    logic rd_only;

    // Write wins over read
    assign rd_only = i_cmd_rd && !i_cmd_wr;

    ////////////////////////////////////////////////////////////
    // Command path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_glb_wr <= 1'b0;
            o_glb_rd <= 1'b0;
            o_gcl_wr <= 1'b0;
            o_gcl_rd <= 1'b0;
        end else begin
            // Unused block ids strobe nothing
            o_glb_wr <= i_cmd_wr && (i_cmd_block == BLK_GLOBAL);
            o_glb_rd <= rd_only && (i_cmd_block == BLK_GLOBAL);
            o_gcl_wr <= i_cmd_wr && (i_cmd_block == BLK_GATE);
            o_gcl_rd <= rd_only && (i_cmd_block == BLK_GATE);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd_wr || i_cmd_rd) begin
            o_blk_addr       <= i_cmd_addr;
            o_blk_addr_fixed <= i_cmd_addr_fixed;
            o_blk_wdata      <= i_cmd_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reply path
    ////////////////////////////////////////////////////////////

    // Equal block latency keeps the two replies apart
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rpl_valid      <= 1'b0;
            o_rpl_block      <= '0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end else if (i_glb_rpl_valid) begin
            o_rpl_valid      <= 1'b1;
            o_rpl_block      <= BLK_GLOBAL;
            o_rpl_addr       <= i_glb_rpl_addr;
            o_rpl_addr_fixed <= i_glb_rpl_addr_fixed;
            o_rpl_data       <= i_glb_rpl_data;
        end else if (i_gcl_rpl_valid) begin
            o_rpl_valid      <= 1'b1;
            o_rpl_block      <= BLK_GATE;
            o_rpl_addr       <= i_gcl_rpl_addr;
            o_rpl_addr_fixed <= i_gcl_rpl_addr_fixed;
            o_rpl_data       <= i_gcl_rpl_data;
        end else begin
            o_rpl_valid      <= 1'b0;
            o_rpl_block      <= '0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end
    end

endmodule

/* hdl/global_registers_management.sv */
// Global configuration register file with write decode and one-cycle read reply
`timescale 1ns/100ps

module global_registers_management
    import tsn_cfg_pkg::*;
#(
    parameter cfg_data_t TSE_VER = 32'h0000_3410
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr,
    input  logic       i_rd,
    input  cfg_addr_t  i_addr,
    input  logic       i_addr_fixed,
    input  cfg_data_t  i_wdata,
    output logic       o_rpl_valid,
    output cfg_addr_t  o_rpl_addr,
    output logic       o_rpl_addr_fixed,
    output cfg_data_t  o_rpl_data,
    output cfg_data_t  o_tse_ver,
    output hw_stage_t  o_hardware_stage,
    output threshold_t o_be_threshold,
    output threshold_t o_rc_threshold,
    output threshold_t o_stdpkt_threshold,
    output logic       o_qbv_or_qch,
    output slot_len_t  o_time_slot_length,
    output slot_len_t  o_schedule_period
);

    logic      rd_hit;
    cfg_data_t rd_data;
    logic      rd_en;

    assign o_tse_ver = TSE_VER;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hardware_stage   <= '0;
            o_rc_threshold     <= '0;
            o_be_threshold     <= '0;
            o_stdpkt_threshold <= '0;
            o_qbv_or_qch       <= 1'b1;
            o_schedule_period  <= 11'd2;
            o_time_slot_length <= 11'd4;
        end else if (i_wr) begin
            if (!i_addr_fixed) begin
                if (i_addr == '0) begin
                    o_hardware_stage <= i_wdata[2:0];
                end
            end else begin
                case (i_addr)
                    19'd0: o_rc_threshold     <= i_wdata[8:0];
                    19'd1: o_be_threshold     <= i_wdata[8:0];
                    19'd2: o_stdpkt_threshold <= i_wdata[8:0];
                    19'd3: o_qbv_or_qch       <= i_wdata[0];
                    19'd4: o_schedule_period  <= i_wdata[10:0];
                    19'd5: o_time_slot_length <= i_wdata[10:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read decode and reply
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        if (!i_addr_fixed) begin
            rd_hit  = (i_addr == '0);
            rd_data = cfg_data_t'(o_hardware_stage);
        end else begin
            case (i_addr)
                19'd0: rd_data = cfg_data_t'(o_rc_threshold);
                19'd1: rd_data = cfg_data_t'(o_be_threshold);
                19'd2: rd_data = cfg_data_t'(o_stdpkt_threshold);
                19'd3: rd_data = cfg_data_t'(o_qbv_or_qch);
                19'd4: rd_data = cfg_data_t'(o_schedule_period);
                19'd5: rd_data = cfg_data_t'(o_time_slot_length);
                default: rd_hit = 1'b0;
            endcase
        end
    end

    // Unmapped reads stay silent
    assign rd_en = i_rd && !i_wr && rd_hit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rpl_valid      <= 1'b0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end else if (rd_en) begin
            o_rpl_valid      <= 1'b1;
            o_rpl_addr       <= i_addr;
            o_rpl_addr_fixed <= i_addr_fixed;
            o_rpl_data       <= rd_data;
        end else begin
            o_rpl_valid      <= 1'b0;
            o_rpl_addr       <= '0;
            o_rpl_addr_fixed <= 1'b0;
            o_rpl_data       <= '0;
        end
    end

endmodule

/* hdl/tsn_cfg_top.sv */
// Configuration and gate-timing core of the TSN switch
`timescale 1ns/100ps

module tsn_cfg_top
    import tsn_cfg_pkg::*;
#(
    parameter cfg_data_t TSE_VER   = 32'h0000_3410,
    parameter int        GCL_DEPTH = 16,
    localparam int       SLOT_W    = $clog2(GCL_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_cmd_wr,
    input  logic              i_cmd_rd,
    input  block_id_t         i_cmd_block,
    input  cfg_addr_t         i_cmd_addr,
    input  logic              i_cmd_addr_fixed,
    input  cfg_data_t         i_cmd_wdata,
    output logic              o_rpl_valid,
    output block_id_t         o_rpl_block,
    output cfg_addr_t         o_rpl_addr,
    output logic              o_rpl_addr_fixed,
    output cfg_data_t         o_rpl_data,
    output cfg_data_t         o_tse_ver,
    output threshold_t        o_be_threshold,
    output threshold_t        o_rc_threshold,
    output threshold_t        o_stdpkt_threshold,
    output logic [SLOT_W-1:0] o_slot_index,
    output gate_state_t       o_gate_state
);

    // Router to blocks
    logic        glb_wr;
    logic        glb_rd;
    logic        gcl_wr;
    logic        gcl_rd;
    cfg_addr_t   blk_addr;
    logic        blk_addr_fixed;
    cfg_data_t   blk_wdata;
    // Blocks to router
    logic        glb_rpl_valid;
    cfg_addr_t   glb_rpl_addr;
    logic        glb_rpl_addr_fixed;
    cfg_data_t   glb_rpl_data;
    logic        gcl_rpl_valid;
    cfg_addr_t   gcl_rpl_addr;
    logic        gcl_rpl_addr_fixed;
    cfg_data_t   gcl_rpl_data;
    // Configuration and scheduling
    hw_stage_t   hardware_stage;
    logic        qbv_or_qch;
    slot_len_t   time_slot_length;
    slot_len_t   schedule_period;
    gate_state_t slot_gate;

    cfg_access_router u_router (
        .i_clk, .i_rst_n,
        .i_cmd_wr, .i_cmd_rd, .i_cmd_block, .i_cmd_addr, .i_cmd_addr_fixed, .i_cmd_wdata,
        .o_glb_wr(glb_wr), .o_glb_rd(glb_rd), .o_gcl_wr(gcl_wr), .o_gcl_rd(gcl_rd),
        .o_blk_addr(blk_addr), .o_blk_addr_fixed(blk_addr_fixed), .o_blk_wdata(blk_wdata),
        .i_glb_rpl_valid(glb_rpl_valid), .i_glb_rpl_addr(glb_rpl_addr),
        .i_glb_rpl_addr_fixed(glb_rpl_addr_fixed), .i_glb_rpl_data(glb_rpl_data),
        .i_gcl_rpl_valid(gcl_rpl_valid), .i_gcl_rpl_addr(gcl_rpl_addr),
        .i_gcl_rpl_addr_fixed(gcl_rpl_addr_fixed), .i_gcl_rpl_data(gcl_rpl_data),
        .o_rpl_valid, .o_rpl_block, .o_rpl_addr, .o_rpl_addr_fixed, .o_rpl_data
    );

    global_registers_management #(.TSE_VER(TSE_VER)) u_global_regs (
        .i_clk, .i_rst_n,
        .i_wr(glb_wr), .i_rd(glb_rd), .i_addr(blk_addr),
        .i_addr_fixed(blk_addr_fixed), .i_wdata(blk_wdata),
        .o_rpl_valid(glb_rpl_valid), .o_rpl_addr(glb_rpl_addr),
        .o_rpl_addr_fixed(glb_rpl_addr_fixed), .o_rpl_data(glb_rpl_data),
        .o_tse_ver, .o_hardware_stage(hardware_stage),
        .o_be_threshold, .o_rc_threshold, .o_stdpkt_threshold,
        .o_qbv_or_qch(qbv_or_qch), .o_time_slot_length(time_slot_length),
        .o_schedule_period(schedule_period)
    );

    gate_control_list #(.GCL_DEPTH(GCL_DEPTH)) u_gcl (
        .i_clk, .i_rst_n,
        .i_wr(gcl_wr), .i_rd(gcl_rd), .i_addr(blk_addr),
        .i_addr_fixed(blk_addr_fixed), .i_wdata(blk_wdata),
        .o_rpl_valid(gcl_rpl_valid), .o_rpl_addr(gcl_rpl_addr),
        .o_rpl_addr_fixed(gcl_rpl_addr_fixed), .o_rpl_data(gcl_rpl_data),
        .i_slot_index(o_slot_index), .o_slot_gate(slot_gate)
    );

    time_slot_scheduler #(.GCL_DEPTH(GCL_DEPTH)) u_scheduler (
        .i_clk, .i_rst_n,
        .i_hardware_stage(hardware_stage), .i_qbv_or_qch(qbv_or_qch),
        .i_time_slot_length(time_slot_length), .i_schedule_period(schedule_period),
        .i_slot_gate(slot_gate), .o_slot_index, .o_gate_state
    );

endmodule

/* tsn_cfg_top.f */
common/tsn_cfg_pkg.sv
hdl/cfg_access_router.sv
hdl/global_registers_management.sv
gate_control/gate_control_list.sv
gate_control/time_slot_scheduler.sv
hdl/tsn_cfg_top.sv
verification/tb_tsn_cfg_top.sv

/* verification/tb_tsn_cfg_top.sv */
// Self-checking testbench for the TSN configuration and gate-timing core
`timescale 1ns/100ps

module tb_tsn_cfg_top;
    import tsn_cfg_pkg::*;

    localparam cfg_data_t TSE_VER   = 32'h0102_0304;
    localparam int        GCL_DEPTH = 16;
    localparam int        SLOT_W    = $clog2(GCL_DEPTH);

    // Worst-case phase lengths in cycles
    localparam int T_RESET    = 20;
    localparam int T_RDWR     = 70;
    localparam int T_UNMAPPED = 80;
    localparam int T_BOTH     = 40;
    localparam int T_SLOT     = 2 * (2 * 9 * 16 + 30);
    localparam int T_GATE     = 120 + 200 + 150 + 3 * 30;
    localparam int TIMEOUT_CYCLES =
        2 * (T_RESET + T_RDWR + T_UNMAPPED + T_BOTH + T_SLOT + T_GATE);

    logic              i_clk;
    logic              i_rst_n;
    logic              i_cmd_wr;
    logic              i_cmd_rd;
    block_id_t         i_cmd_block;
    cfg_addr_t         i_cmd_addr;
    logic              i_cmd_addr_fixed;
    cfg_data_t         i_cmd_wdata;
    logic              o_rpl_valid;
    block_id_t         o_rpl_block;
    cfg_addr_t         o_rpl_addr;
    logic              o_rpl_addr_fixed;
    cfg_data_t         o_rpl_data;
    cfg_data_t         o_tse_ver;
    threshold_t        o_be_threshold;
    threshold_t        o_rc_threshold;
    threshold_t        o_stdpkt_threshold;
    logic [SLOT_W-1:0] o_slot_index;
    gate_state_t       o_gate_state;

    integer seed;

    // Shadow register map, thresholds ordered rc, be, stdpkt
    hw_stage_t   sh_stage;
    threshold_t  sh_thr [3];
    logic        sh_qbv;
    slot_len_t   sh_period;
    slot_len_t   sh_len;
    gate_state_t sh_gcl [GCL_DEPTH];

    // Expected replies with the cycle they are due in
    block_id_t exp_blk_q [$];
    cfg_addr_t exp_addr_q [$];
    logic      exp_fixed_q [$];
    cfg_data_t exp_data_q [$];
    int        exp_due_q [$];

    int                cyc = 0;
    logic [SLOT_W-1:0] prev_slot = '0;
    logic              slot_chk_on = 1'b0;
    logic              gate_chk_on = 1'b0;
    logic              seen_change = 1'b0;
    int                since_change = 0;
    block_id_t         mon_blk;
    cfg_addr_t         mon_addr;
    logic              mon_fixed;
    cfg_data_t         mon_data;
    int                mon_due;

    tsn_cfg_top #(.TSE_VER(TSE_VER), .GCL_DEPTH(GCL_DEPTH)) i_tsn_cfg_top (
        .i_clk, .i_rst_n,
        .i_cmd_wr, .i_cmd_rd, .i_cmd_block, .i_cmd_addr, .i_cmd_addr_fixed, .i_cmd_wdata,
        .o_rpl_valid, .o_rpl_block, .o_rpl_addr, .o_rpl_addr_fixed, .o_rpl_data,
        .o_tse_ver, .o_be_threshold, .o_rc_threshold, .o_stdpkt_threshold,
        .o_slot_index, .o_gate_state
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic cfg_data_t ref_read(input block_id_t blk, input logic fixed,
                                           input cfg_addr_t addr, output logic hit);
        cfg_data_t data;
        data = '0;
        hit  = 1'b0;
        if (blk == 2'd0 && !fixed && addr == 0) begin
            hit  = 1'b1;
            data = {29'd0, sh_stage};
        end else if (blk == 2'd0 && fixed && addr <= 5) begin
            hit = 1'b1;
            case (addr)
                0, 1, 2: data = {23'd0, sh_thr[addr]};
                3:       data = {31'd0, sh_qbv};
                4:       data = {21'd0, sh_period};
                default: data = {21'd0, sh_len};
            endcase
        end else if (blk == 2'd1 && !fixed && addr < GCL_DEPTH) begin
            hit  = 1'b1;
            data = {24'd0, sh_gcl[addr]};
        end
        return data;
    endfunction

    function automatic void ref_write(input block_id_t blk, input logic fixed,
                                      input cfg_addr_t addr, input cfg_data_t data);
        if (blk == 2'd0 && !fixed && addr == 0) begin
            sh_stage = data[2:0];
        end else if (blk == 2'd0 && fixed) begin
            case (addr)
                0, 1, 2: sh_thr[addr] = data[8:0];
                3:       sh_qbv = data[0];
                4:       sh_period = data[10:0];
                5:       sh_len = data[10:0];
                default: ;
            endcase
        end else if (blk == 2'd1 && !fixed && addr < GCL_DEPTH) begin
            sh_gcl[addr] = data[7:0];
        end
    endfunction

    function automatic gate_state_t ref_gate(input logic [SLOT_W-1:0] slot);
        gate_state_t gate;
        if (sh_stage != 3'd3) begin
            gate = 8'hff;
        end else if (sh_qbv) begin
            gate = sh_gcl[slot];
        end else begin
            // Queue 7 closed in odd slots, queue 6 in even ones
            gate = slot[0] ? 8'h7f : 8'hbf;
        end
        return gate;
    endfunction

    function automatic logic [SLOT_W-1:0] ref_next_slot(input logic [SLOT_W-1:0] slot);
        logic [SLOT_W-1:0] nxt;
        if (int'(slot) + 1 >= int'(sh_period)) begin
            nxt = '0;
        end else begin
            nxt = slot + 1'b1;
        end
        return nxt;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    ////////////////////////////////////////////////////////////
    // Error reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_reply(input block_id_t g_blk, input cfg_addr_t g_addr,
                               input logic g_fixed, input cfg_data_t g_data,
                               input block_id_t e_blk, input cfg_addr_t e_addr,
                               input logic e_fixed, input cfg_data_t e_data);
        if (g_blk !== e_blk || g_addr !== e_addr || g_fixed !== e_fixed
            || g_data !== e_data) begin
            report_mismatch($sformatf(
                "reply blk %0d addr %0h fixed %0b data %h, expected %0d %0h %0b %h",
                g_blk, g_addr, g_fixed, g_data, e_blk, e_addr, e_fixed, e_data));
        end
    endtask

    task automatic check_gate(input gate_state_t got, input gate_state_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("gate state %b, expected %b", got, exp));
        end
    endtask

    task automatic check_slot(input logic [SLOT_W-1:0] got, input logic [SLOT_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("slot index %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_threshold(input threshold_t got, input threshold_t exp,
                                   input string name);
        if (got !== exp) begin
            report_mismatch($sformatf("%s threshold %0d, expected %0d", name, got, exp));
        end
    endtask

    task automatic check_version(input cfg_data_t got, input cfg_data_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("version %h, expected %h", got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor
    ////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            report_error("the run passed its cycle limit without finishing");
        end
        if (o_rpl_valid === 1'b1) begin
            if (exp_due_q.size() == 0) begin
                report_error("a reply arrived with no read pending");
            end
            mon_blk   = exp_blk_q.pop_front();
            mon_addr  = exp_addr_q.pop_front();
            mon_fixed = exp_fixed_q.pop_front();
            mon_data  = exp_data_q.pop_front();
            mon_due   = exp_due_q.pop_front();
            if (mon_due != cyc) begin
                report_error("a reply arrived earlier than three edges after its read");
            end
            check_reply(o_rpl_block, o_rpl_addr, o_rpl_addr_fixed, o_rpl_data,
                        mon_blk, mon_addr, mon_fixed, mon_data);
        end else begin
            if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
                report_error("an expected reply did not arrive");
            end
            check_reply(o_rpl_block, o_rpl_addr, o_rpl_addr_fixed, o_rpl_data,
                        2'd0, '0, 1'b0, '0);
        end
        if (slot_chk_on) begin
            if (o_slot_index !== prev_slot) begin
                check_slot(o_slot_index, ref_next_slot(prev_slot));
                if (seen_change && since_change != int'(sh_len)) begin
                    report_error("a slot lasted a different number of cycles than its length");
                end
                since_change = 1;
                seen_change  = 1'b1;
            end else begin
                since_change = since_change + 1;
                if (since_change > int'(sh_len)) begin
                    report_error("the slot index stopped advancing");
                end
            end
        end
        // Gate state lags the slot index by one cycle
        if (gate_chk_on) begin
            check_gate(o_gate_state, ref_gate(prev_slot));
        end
        prev_slot = o_slot_index;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_cmd(input logic wr, input logic rd, input block_id_t blk,
                            input logic fixed, input cfg_addr_t addr, input cfg_data_t data);
        logic      hit;
        cfg_data_t exp;
        i_cmd_wr         = wr;
        i_cmd_rd         = rd;
        i_cmd_block      = blk;
        i_cmd_addr       = addr;
        i_cmd_addr_fixed = fixed;
        i_cmd_wdata      = data;
        if (wr) begin
            ref_write(blk, fixed, addr, data);
        end else if (rd) begin
            exp = ref_read(blk, fixed, addr, hit);
            if (hit) begin
                exp_blk_q.push_back(blk);
                exp_addr_q.push_back(addr);
                exp_fixed_q.push_back(fixed);
                exp_data_q.push_back(exp);
                exp_due_q.push_back(cyc + 4);
            end
        end
        @(negedge i_clk);
    endtask

    task automatic go_idle();
        i_cmd_wr = 1'b0;
        i_cmd_rd = 1'b0;
    endtask

    task automatic wait_replies();
        while (exp_due_q.size() != 0) begin
            @(negedge i_clk);
        end
    endtask

    task automatic read_all();
        send_cmd(1'b0, 1'b1, BLK_GLOBAL, 1'b0, '0, '0);
        for (int a = 0; a < 6; a++) begin
            send_cmd(1'b0, 1'b1, BLK_GLOBAL, 1'b1, cfg_addr_t'(a), '0);
        end
        for (int a = 0; a < GCL_DEPTH; a++) begin
            send_cmd(1'b0, 1'b1, BLK_GATE, 1'b0, cfg_addr_t'(a), '0);
        end
        go_idle();
        wait_replies();
    endtask

    task automatic unmapped_access(input logic wr);
        send_cmd(wr, !wr, BLK_GLOBAL, 1'b0, 19'd1, $random(seed));
        send_cmd(wr, !wr, BLK_GLOBAL, 1'b0, 19'h7ffff, $random(seed));
        send_cmd(wr, !wr, BLK_GLOBAL, 1'b1, 19'd6, $random(seed));
        send_cmd(wr, !wr, BLK_GLOBAL, 1'b1, cfg_addr_t'(7 + rand_below(5000)), $random(seed));
        send_cmd(wr, !wr, BLK_GATE, 1'b0, cfg_addr_t'(GCL_DEPTH), $random(seed));
        send_cmd(wr, !wr, BLK_GATE, 1'b1, 19'd3, $random(seed));
        send_cmd(wr, !wr, BLK_GATE, 1'b0, cfg_addr_t'(100 + rand_below(5000)), $random(seed));
        send_cmd(wr, !wr, 2'd2, 1'b0, 19'd0, $random(seed));
        send_cmd(wr, !wr, 2'd3, 1'b1, 19'd3, $random(seed));
        send_cmd(wr, !wr, 2'd3, 1'b0, 19'd5, $random(seed));
        go_idle();
    endtask

    task automatic run_schedule(input hw_stage_t stage, input logic qbv, input int len,
                                input int per, input int cycles);
        slot_chk_on = 1'b0;
        gate_chk_on = 1'b0;
        send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b0, 19'd0, cfg_data_t'(stage));
        send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b1, 19'd3, cfg_data_t'(qbv));
        send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b1, 19'd4, cfg_data_t'(per));
        send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b1, 19'd5, cfg_data_t'(len));
        go_idle();
        repeat (8) @(negedge i_clk);
        since_change = 0;
        seen_change  = 1'b0;
        slot_chk_on  = 1'b1;
        gate_chk_on  = 1'b1;
        repeat (cycles) @(negedge i_clk);
        slot_chk_on = 1'b0;
        gate_chk_on = 1'b0;
    endtask

    initial begin
        int slot_len;
        int period;
        seed             = 32'h85d5a81c;
        i_rst_n          = 1'b0;
        i_cmd_wr         = 1'b0;
        i_cmd_rd         = 1'b0;
        i_cmd_block      = '0;
        i_cmd_addr       = '0;
        i_cmd_addr_fixed = 1'b0;
        i_cmd_wdata      = '0;
        sh_stage  = '0;
        sh_qbv    = 1'b1;
        sh_period = 11'd2;
        sh_len    = 11'd4;
        for (int i = 0; i < 3; i++) begin
            sh_thr[i] = '0;
        end
        for (int i = 0; i < GCL_DEPTH; i++) begin
            sh_gcl[i] = '0;
        end
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // Reset values
        read_all();
        check_version(o_tse_ver, TSE_VER);

        // Random writes, then back-to-back reads
        send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b0, 19'd0, $random(seed));
        for (int a = 0; a < 6; a++) begin
            send_cmd(1'b1, 1'b0, BLK_GLOBAL, 1'b1, cfg_addr_t'(a), $random(seed));
        end
        for (int a = 0; a < GCL_DEPTH; a++) begin
            send_cmd(1'b1, 1'b0, BLK_GATE, 1'b0, cfg_addr_t'(a), $random(seed));
        end
        read_all();
        check_threshold(o_rc_threshold, sh_thr[0], "rc");
        check_threshold(o_be_threshold, sh_thr[1], "be");
        check_threshold(o_stdpkt_threshold, sh_thr[2], "stdpkt");

        // Unmapped targets stay silent and change nothing
        unmapped_access(1'b1);
        unmapped_access(1'b0);
        repeat (6) @(negedge i_clk);
        read_all();

        // Write wins when both strobes are high
        send_cmd(1'b1, 1'b1, BLK_GLOBAL, 1'b1, 19'd0, $random(seed));
        send_cmd(1'b1, 1'b1, BLK_GATE, 1'b0, 19'd5, $random(seed));
        send_cmd(1'b1, 1'b1, BLK_GLOBAL, 1'b0, 19'd0, $random(seed));
        go_idle();
        repeat (6) @(negedge i_clk);
        read_all();

        ////////////////////////////////////////////////////////////
        // Slot timing and gate state
        ////////////////////////////////////////////////////////////

        for (int k = 0; k < 2; k++) begin
            slot_len = 2 + rand_below(8);
            period   = 2 + rand_below(15);
            run_schedule(k ? 3'd3 : 3'd0, 1'b0, slot_len, period, 2 * slot_len * period);
        end
        run_schedule(3'd5, 1'b1, 3, 4, 120);
        for (int a = 0; a < GCL_DEPTH; a++) begin
            send_cmd(1'b1, 1'b0, BLK_GATE, 1'b0, cfg_addr_t'(a), $random(seed));
        end
        run_schedule(3'd3, 1'b1, 2 + rand_below(4), 16, 200);
        run_schedule(3'd3, 1'b0, 2 + rand_below(4), 5, 150);
        wait_replies();

        $display("No errors");
        $finish;
    end

endmodule
